// ==== bmem_pkg.sv ====
`default_nettype none

package bmem_pkg;

    // instruction word and bus beat widths
    localparam int WORD_BITS = 32;
    localparam int BEAT_BITS = 64;

    // one cache line
    localparam int LINE_BITS = 256;
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

    // byte offset within a line
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);

    // bus side sees beats, fetch side sees words
    // beat 0 and words 0/1 sit in the low bits
    typedef union packed {
        logic [BEATS_PER_LINE-1:0][BEAT_BITS-1:0] beats;
        logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] words;
    } line_t;

endpackage

`default_nettype wire

// ==== beat_counter.sv ====
`default_nettype none

module beat_counter
    import bmem_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       clear_i,
    input  wire logic       count_en_i,
    output logic      [1:0] beat_idx_o,
    output logic            last_beat_o
);

    logic [1:0] count_q;

    // clear wins over count
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= 2'd0;
        end else if (clear_i) begin
            count_q <= 2'd0;
        end else if (count_en_i) begin
            count_q <= count_q + 2'd1;
        end
    end

    assign beat_idx_o = count_q;

    // final beat of the line
    assign last_beat_o = (count_q == 2'(BEATS_PER_LINE - 1));

endmodule

`default_nettype wire

// ==== line_beat_buffer.sv ====
`default_nettype none

module line_beat_buffer
    import bmem_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst,

    // whole line from the data port at write start
    input  wire line_t                wdata_i,
    input  wire logic                 load_wdata_i,

    // read beats coming off the bus
    input  wire logic                 capture_i,
    input  wire logic [1:0]           beat_idx_i,
    input  wire logic [BEAT_BITS-1:0] beat_i,

    output line_t                     line_o,
    output logic      [BEAT_BITS-1:0] beat_o
);

    line_t line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (load_wdata_i) begin
            line_q <= wdata_i;
        end else if (capture_i) begin
            // drop the arriving beat into its slot
            line_q.beats[beat_idx_i] <= beat_i;
        end
    end

    // current write beat for the bus
    assign beat_o = line_q.beats[beat_idx_i];

    assign line_o = line_q;

endmodule

`default_nettype wire

// ==== inst_line_buffer.sv ====
`default_nettype none

module inst_line_buffer
    import bmem_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // lookup
    input  wire logic [ADDR_W-1:0] fetch_addr_i,
    output logic                   hit_o,
    output logic [WORD_BITS-1:0]   word_o,

    // refill from the bus
    input  wire logic              fill_i,
    input  wire line_t             fill_line_i,
    input  wire logic [ADDR_W-1:0] fill_addr_i,

    // data write snoop
    input  wire logic              inval_i,
    input  wire logic [ADDR_W-1:0] inval_addr_i
);

    localparam int TAG_W = ADDR_W - OFFSET_BITS;

    logic             valid_q;
    logic [TAG_W-1:0] tag_q;
    line_t            line_q;

    logic             inval_match;

    assign inval_match = (inval_addr_i[ADDR_W-1:OFFSET_BITS] == tag_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_i) begin
            valid_q <= 1'b1;
        end else if (inval_i && inval_match) begin
            // stale copy after a data write
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q  <= fill_addr_i[ADDR_W-1:OFFSET_BITS];
            line_q <= fill_line_i;
        end
    end

    assign hit_o = valid_q && (tag_q == fetch_addr_i[ADDR_W-1:OFFSET_BITS]);

    // word select by addr bits 4:2
    assign word_o = line_q.words[fetch_addr_i[OFFSET_BITS-1:2]];

endmodule

`default_nettype wire

// ==== bridge_fsm.sv ====
`default_nettype none

module bridge_fsm
    import bmem_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,

    // fetch port
    input  wire logic              fetch_req_i,
    input  wire logic [ADDR_W-1:0] fetch_addr_i,
    input  wire logic              fetch_hit_i,
    output logic                   fetch_resp_o,

    // data port
    input  wire logic              dline_read_i,
    input  wire logic              dline_write_i,
    input  wire logic [ADDR_W-1:0] dline_addr_i,
    output logic                   dline_resp_o,

    // memory bus
    input  wire logic              bmem_ready_i,
    input  wire logic              bmem_rvalid_i,
    output logic                   bmem_read_o,
    output logic                   bmem_write_o,
    output logic [ADDR_W-1:0]      bmem_addr_o,

    // datapath control
    input  wire logic              last_beat_i,
    output logic                   beat_count_en_o,
    output logic                   beat_clear_o,
    output logic                   capture_o,
    output logic                   load_wdata_o,
    output logic                   fill_done_o
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_RD_ISSUE = 3'd1;
    localparam logic [2:0] S_RD_WAIT  = 3'd2;
    localparam logic [2:0] S_WR_BEATS = 3'd3;
    localparam logic [2:0] S_RESPOND  = 3'd4;

    logic [2:0]        state_q;
    logic              serve_data_q;
    logic [ADDR_W-1:0] addr_q;

    logic              data_pending;
    logic              rd_beat;
    logic              wr_beat;

    assign data_pending = dline_read_i || dline_write_i;
    assign rd_beat      = (state_q == S_RD_WAIT) && bmem_rvalid_i;
    assign wr_beat      = (state_q == S_WR_BEATS) && bmem_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= S_IDLE;
            serve_data_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    // data port has priority
                    if (data_pending) begin
                        serve_data_q <= 1'b1;
                        state_q      <= dline_write_i ? S_WR_BEATS : S_RD_ISSUE;
                    end else if (fetch_req_i) begin
                        serve_data_q <= 1'b0;
                        state_q      <= fetch_hit_i ? S_RESPOND : S_RD_ISSUE;
                    end
                end
                S_RD_ISSUE: begin
                    if (bmem_ready_i) begin
                        state_q <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (rd_beat && last_beat_i) begin
                        state_q <= S_RESPOND;
                    end
                end
                S_WR_BEATS: begin
                    if (wr_beat && last_beat_i) begin
                        state_q <= S_RESPOND;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // line address, offset cleared
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            if (data_pending) begin
                addr_q <= {dline_addr_i[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end else if (fetch_req_i) begin
                addr_q <= {fetch_addr_i[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            end
        end
    end

    assign bmem_read_o  = (state_q == S_RD_ISSUE);
    assign bmem_write_o = (state_q == S_WR_BEATS);
    assign bmem_addr_o  = addr_q;

    assign beat_clear_o    = (state_q == S_IDLE);
    assign beat_count_en_o = rd_beat || wr_beat;
    assign capture_o       = rd_beat;

    // write line is loaded as the write is taken
    assign load_wdata_o = (state_q == S_IDLE) && dline_write_i;

    // last beat of an instruction fill
    assign fill_done_o = rd_beat && last_beat_i && !serve_data_q;

    assign fetch_resp_o = (state_q == S_RESPOND) && !serve_data_q;
    assign dline_resp_o = (state_q == S_RESPOND) && serve_data_q;

endmodule

`default_nettype wire

// ==== bmem_bridge.sv ====
`default_nettype none

module bmem_bridge
    import bmem_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // instruction fetch port
    input  wire logic                 fetch_req_i,
    input  wire logic [ADDR_W-1:0]    fetch_addr_i,
    output logic                      fetch_resp_o,
    output logic      [WORD_BITS-1:0] fetch_word_o,

    // data line port
    input  wire logic                 dline_read_i,
    input  wire logic                 dline_write_i,
    input  wire logic [ADDR_W-1:0]    dline_addr_i,
    input  wire logic [LINE_BITS-1:0] dline_wdata_i,
    output logic                      dline_resp_o,
    output logic      [LINE_BITS-1:0] dline_rdata_o,

    // burst memory bus
    output logic      [ADDR_W-1:0]    bmem_addr_o,
    output logic                      bmem_read_o,
    output logic                      bmem_write_o,
    output logic      [BEAT_BITS-1:0] bmem_wdata_o,
    input  wire logic                 bmem_ready_i,
    input  wire logic [BEAT_BITS-1:0] bmem_rdata_i,
    input  wire logic                 bmem_rvalid_i
);

    logic       fetch_hit;
    logic       beat_count_en;
    logic       beat_clear;
    logic       capture;
    logic       load_wdata;
    logic       fill_done;
    logic [1:0] beat_idx;
    logic       last_beat;
    logic       inval;

    line_t      buf_line;
    line_t      fill_line;

    bridge_fsm #(
        .ADDR_W          (ADDR_W)
    ) bridge_fsm_i (
        .clk             (clk),
        .rst             (rst),
        .fetch_req_i     (fetch_req_i),
        .fetch_addr_i    (fetch_addr_i),
        .fetch_hit_i     (fetch_hit),
        .fetch_resp_o    (fetch_resp_o),
        .dline_read_i    (dline_read_i),
        .dline_write_i   (dline_write_i),
        .dline_addr_i    (dline_addr_i),
        .dline_resp_o    (dline_resp_o),
        .bmem_ready_i    (bmem_ready_i),
        .bmem_rvalid_i   (bmem_rvalid_i),
        .bmem_read_o     (bmem_read_o),
        .bmem_write_o    (bmem_write_o),
        .bmem_addr_o     (bmem_addr_o),
        .last_beat_i     (last_beat),
        .beat_count_en_o (beat_count_en),
        .beat_clear_o    (beat_clear),
        .capture_o       (capture),
        .load_wdata_o    (load_wdata),
        .fill_done_o     (fill_done)
    );

    beat_counter beat_counter_i (
        .clk         (clk),
        .rst         (rst),
        .clear_i     (beat_clear),
        .count_en_i  (beat_count_en),
        .beat_idx_o  (beat_idx),
        .last_beat_o (last_beat)
    );

    line_beat_buffer line_beat_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .wdata_i      (dline_wdata_i),
        .load_wdata_i (load_wdata),
        .capture_i    (capture),
        .beat_idx_i   (beat_idx),
        .beat_i       (bmem_rdata_i),
        .line_o       (buf_line),
        .beat_o       (bmem_wdata_o)
    );

    assign dline_rdata_o = buf_line;

    // fill line: captured beats plus the one arriving now
    assign fill_line = line_t'({bmem_rdata_i, buf_line.beats[BEATS_PER_LINE-2:0]});

    // completed data write snoops the fetch line
    assign inval = dline_resp_o && dline_write_i;

    inst_line_buffer #(
        .ADDR_W       (ADDR_W)
    ) inst_line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_addr_i (fetch_addr_i),
        .hit_o        (fetch_hit),
        .word_o       (fetch_word_o),
        .fill_i       (fill_done),
        .fill_line_i  (fill_line),
        .fill_addr_i  (bmem_addr_o),
        .inval_i      (inval),
        .inval_addr_i (dline_addr_i)
    );

endmodule

`default_nettype wire

// ==== bmem_bridge_sva.sv ====
`default_nettype none

module bmem_bridge_sva
    import bmem_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 fetch_resp_o,
    input wire logic                 dline_resp_o,
    input wire logic                 bmem_read_o,
    input wire logic                 bmem_write_o,
    input wire logic [ADDR_W-1:0]    bmem_addr_o,
    input wire logic [BEAT_BITS-1:0] bmem_wdata_o,
    input wire logic                 bmem_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // read command is issued once
    read_drop: assert property (@(posedge clk) disable iff (rst)
        (bmem_read_o && bmem_ready_i) |=> !bmem_read_o)
        else $error("read command still high after it was accepted");

    // stalled command holds still
    read_hold: assert property (@(posedge clk) disable iff (rst)
        (bmem_read_o && !bmem_ready_i) |=> (bmem_read_o && $stable(bmem_addr_o)))
        else $error("read command changed while ready was low");

    write_hold: assert property (@(posedge clk) disable iff (rst)
        (bmem_write_o && !bmem_ready_i) |=>
            (bmem_write_o && $stable(bmem_addr_o) && $stable(bmem_wdata_o)))
        else $error("write command or beat changed while ready was low");

    fetch_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_resp_o |=> !fetch_resp_o)
        else $error("fetch response longer than one cycle");

    dline_pulse: assert property (@(posedge clk) disable iff (rst)
        dline_resp_o |=> !dline_resp_o)
        else $error("data response longer than one cycle");

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!fetch_resp_o && !dline_resp_o))
        else $error("response high out of reset");

endmodule

bind bmem_bridge bmem_bridge_sva #(
    .ADDR_W       (ADDR_W)
) bmem_bridge_sva_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_resp_o (fetch_resp_o),
    .dline_resp_o (dline_resp_o),
    .bmem_read_o  (bmem_read_o),
    .bmem_write_o (bmem_write_o),
    .bmem_addr_o  (bmem_addr_o),
    .bmem_wdata_o (bmem_wdata_o),
    .bmem_ready_i (bmem_ready_i)
);

`default_nettype wire

// ==== tb_bmem_bridge.sv ====
`default_nettype none

module tb_bmem_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W     = 32;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;

    logic              clk = 1'b0;
    logic              rst;
    logic              fetch_req_i;
    logic [ADDR_W-1:0] fetch_addr_i;
    logic              fetch_resp_o;
    logic [31:0]       fetch_word_o;
    logic              dline_read_i;
    logic              dline_write_i;
    logic [ADDR_W-1:0] dline_addr_i;
    logic [255:0]      dline_wdata_i;
    logic              dline_resp_o;
    logic [255:0]      dline_rdata_o;
    logic [ADDR_W-1:0] bmem_addr_o;
    logic              bmem_read_o;
    logic              bmem_write_o;
    logic [63:0]       bmem_wdata_o;
    logic              bmem_ready_i;
    logic [63:0]       bmem_rdata_i;
    logic              bmem_rvalid_i;

    // memory model state
    int           seed = 32'h1b9036ad;
    logic [255:0] mem [logic [31:0]];
    int           read_count;
    time          fetch_done_time;
    time          dline_done_time;

    bmem_bridge #(
        .ADDR_W        (ADDR_W)
    ) bmem_bridge_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_resp_o  (fetch_resp_o),
        .fetch_word_o  (fetch_word_o),
        .dline_read_i  (dline_read_i),
        .dline_write_i (dline_write_i),
        .dline_addr_i  (dline_addr_i),
        .dline_wdata_i (dline_wdata_i),
        .dline_resp_o  (dline_resp_o),
        .dline_rdata_o (dline_rdata_o),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] line_addr(input logic [31:0] addr);
        return {addr[31:5], 5'b0};
    endfunction

    function automatic logic [255:0] random_line();
        logic [255:0] l;
        for (int k = 0; k < 8; k++) begin
            l[k*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // lines appear with random contents on first touch
    function automatic logic [255:0] model_line(input logic [31:0] addr);
        if (!mem.exists(line_addr(addr))) begin
            mem[line_addr(addr)] = random_line();
        end
        return mem[line_addr(addr)];
    endfunction

    // burst memory: sample mid-cycle, drive 1 ns after the edge
    initial begin
        logic         rd_acc;
        logic         wr_acc;
        logic         rd_busy;
        logic [31:0]  s_addr;
        logic [63:0]  s_wdata;
        logic [31:0]  rd_addr;
        logic [255:0] mline;
        int           rd_gap;
        int           rd_beat;
        int           wr_beat;
        bmem_ready_i  = 1'b0;
        bmem_rvalid_i = 1'b0;
        bmem_rdata_i  = '0;
        read_count    = 0;
        rd_busy       = 1'b0;
        rd_addr       = '0;
        rd_gap        = 0;
        rd_beat       = 0;
        wr_beat       = 0;
        forever begin
            @(negedge clk);
            rd_acc  = bmem_read_o && bmem_ready_i;
            wr_acc  = bmem_write_o && bmem_ready_i;
            s_addr  = bmem_addr_o;
            s_wdata = bmem_wdata_o;
            @(posedge clk);
            #1;
            if (!rst) begin
                if (wr_acc) begin
                    mline = model_line(s_addr);
                    mline[wr_beat*64 +: 64] = s_wdata;
                    mem[line_addr(s_addr)] = mline;
                    wr_beat = (wr_beat + 1) % 4;
                end
                if (rd_acc) begin
                    read_count++;
                    rd_addr = line_addr(s_addr);
                    rd_gap  = 2 + ($random(seed) & 3);
                    rd_busy = 1'b1;
                    rd_beat = 0;
                end
                if (rd_busy && rd_gap == 0) begin
                    mline = model_line(rd_addr);
                    bmem_rdata_i  = mline[rd_beat*64 +: 64];
                    bmem_rvalid_i = 1'b1;
                    rd_beat++;
                    if (rd_beat == 4) begin
                        rd_busy = 1'b0;
                    end
                end else begin
                    bmem_rvalid_i = 1'b0;
                    if (rd_gap > 0) begin
                        rd_gap--;
                    end
                end
                // ready on about three cycles in four
                bmem_ready_i = (($random(seed) & 3) != 0);
            end
        end
    end

    task automatic compare_values(input logic [255:0] got, input logic [255:0] exp,
                                  input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fetch_word(input logic [31:0] addr, output logic [31:0] word,
                              output int latency);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        fetch_addr_i = addr;
        fetch_req_i  = 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!fetch_resp_o);
        word            = fetch_word_o;
        latency         = n - 1;
        fetch_done_time = $time;
        @(posedge clk);
        #1;
        fetch_req_i = 1'b0;
    endtask

    task automatic read_line(input logic [31:0] addr, output logic [255:0] line);
        @(posedge clk);
        #1;
        dline_addr_i = addr;
        dline_read_i = 1'b1;
        do begin
            @(negedge clk);
        end while (!dline_resp_o);
        line            = dline_rdata_o;
        dline_done_time = $time;
        @(posedge clk);
        #1;
        dline_read_i = 1'b0;
    endtask

    task automatic write_line(input logic [31:0] addr, input logic [255:0] line);
        @(posedge clk);
        #1;
        dline_addr_i  = addr;
        dline_wdata_i = line;
        dline_write_i = 1'b1;
        do begin
            @(negedge clk);
        end while (!dline_resp_o);
        @(posedge clk);
        #1;
        dline_write_i = 1'b0;
    endtask

    task automatic after_reset_outputs_low();
        @(negedge clk);
        compare_values(256'(fetch_resp_o), 256'(0), "fetch_resp_o after reset");
        compare_values(256'(dline_resp_o), 256'(0), "dline_resp_o after reset");
        compare_values(256'(bmem_read_o), 256'(0), "bmem_read_o after reset");
        compare_values(256'(bmem_write_o), 256'(0), "bmem_write_o after reset");
    endtask

    task automatic fetch_returns_word(input logic [31:0] addr, input bit expect_hit);
        logic [255:0] l;
        logic [31:0]  w;
        int           lat;
        int           rc;
        rc = read_count;
        fetch_word(addr, w, lat);
        l = model_line(addr);
        compare_values(256'(w), 256'(l[int'(addr[4:2])*32 +: 32]), "fetched word");
        if (expect_hit) begin
            compare_values(256'(lat), 256'(1), "hit latency");
            compare_values(256'(read_count), 256'(rc), "bus reads on a hit");
        end else begin
            compare_values(256'(read_count), 256'(rc + 1), "bus reads on a miss");
        end
    endtask

    task automatic data_read_returns_line(input logic [31:0] addr);
        logic [255:0] l;
        read_line(addr, l);
        compare_values(l, model_line(addr), "data line read");
    endtask

    task automatic data_write_updates_line(input logic [31:0] addr);
        logic [255:0] wdata;
        logic [255:0] l;
        wdata = random_line();
        write_line(addr, wdata);
        compare_values(model_line(addr), wdata, "memory line after write");
        read_line(addr, l);
        compare_values(l, wdata, "read back of written line");
        // buffer was invalidated, so this must miss
        fetch_returns_word(addr | 32'h1c, 1'b0);
    endtask

    task automatic shared_cycle_data_first(input logic [31:0] daddr, input logic [31:0] faddr);
        logic [255:0] l;
        logic [255:0] fl;
        logic [31:0]  w;
        int           lat;
        fork
            read_line(daddr, l);
            fetch_word(faddr, w, lat);
        join
        fl = model_line(faddr);
        compare_values(l, model_line(daddr), "data line in shared cycle");
        compare_values(256'(w), 256'(fl[int'(faddr[4:2])*32 +: 32]), "fetch word in shared cycle");
        compare_values(256'(dline_done_time < fetch_done_time), 256'(1),
                       "data response before fetch response");
    endtask

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("watchdog expired: the tests did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst           = 1'b1;
        fetch_req_i   = 1'b0;
        fetch_addr_i  = '0;
        dline_read_i  = 1'b0;
        dline_write_i = 1'b0;
        dline_addr_i  = '0;
        dline_wdata_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        after_reset_outputs_low();
        fetch_returns_word(32'h0000_1234, 1'b0);
        fetch_returns_word(32'h0000_1228, 1'b1);
        data_read_returns_line(32'h0000_8040);
        // same line as the one held by the fetch buffer
        data_write_updates_line(32'h0000_1220);
        shared_cycle_data_first(32'h0000_a000, 32'h0000_c018);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
bmem_pkg.sv
beat_counter.sv
line_beat_buffer.sv
inst_line_buffer.sv
bridge_fsm.sv
bmem_bridge.sv
bmem_bridge_sva.sv
tb_bmem_bridge.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_bmem_bridge -f list.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "simulation build or run failed" >&2; exit 1; }
